/* filelist.f */
rtl/cpu_ctrl_pkg.sv
rtl/opcode_decoder.sv
rtl/operand_select.sv
rtl/cycle_sequencer.sv
rtl/control_decoder.sv
rtl/cpu_controller.sv
tests/cpu_controller_properties.sv
tests/tb_cpu_controller.sv

/* rtl/control_decoder.sv */
`timescale 1ns/1ns

module control_decoder
  import cpu_ctrl_pkg::*;
(
  input  cycle_state_t state,
  input  op_t          op,
  input  addr_mode_t   addr_mode,
  input  logic         branch_taken,
  input  alu_ctrl_t    exe_ctrl,
  input  alu_src_a_t   exe_src_a,
  input  reg_src_t     mov_src,
  input  reg_dst_t     mov_dst,
  input  p_src_t       p_src_sel,
  input  flags_t       flag_mask,
  input  logic         is_load,
  input  logic         is_store,
  input  logic         is_xfer,
  output logic         r_w,
  output db_src_t      db_out_src,
  output logic         dl_we,
  output logic         ir_we,
  output pc_add_t      pc_adder_ctrl,
  output pcl_src_t     pcl_src,
  output logic         pch_src,
  output logic         pcl_we,
  output logic         pch_we,
  output reg_src_t     reg_src,
  output logic         a_we,
  output logic         x_we,
  output logic         y_we,
  output logic         t_we,
  output p_src_t       p_src,
  output flags_t       p_mask,
  output alu_ctrl_t    alu_ctrl,
  output alu_src_a_t   alu_src_a,
  output alu_src_b_t   alu_src_b,
  output ab_src_t      abl_src,
  output ab_src_t      abh_src,
  output logic         abl_we,
  output logic         abh_we
);

  always_comb begin
    r_w           = RW_READ;
    db_out_src    = DB_SRC_A;
    dl_we         = 1'b0;
    ir_we         = 1'b0;
    alu_ctrl      = ALU_THA;
    alu_src_a     = ALU_SRC_A_A;
    alu_src_b     = ALU_SRC_B_T;
    reg_src       = REG_SRC_MEM;
    a_we          = 1'b0;
    x_we          = 1'b0;
    y_we          = 1'b0;
    t_we          = 1'b0;
    p_src         = P_SRC_NON;
    p_mask        = '0;
    pc_adder_ctrl = PC_ADD_NOP;
    pcl_src       = PCL_SRC_ADD;
    pch_src       = PCH_SRC_ADD;
    pcl_we        = 1'b0;
    pch_we        = 1'b0;
    abl_src       = AB_SRC_PCN;
    abh_src       = AB_SRC_PCN;
    abl_we        = 1'b0;
    abh_we        = 1'b0;

    case (state)
      fetch_opcode: begin
        ir_we = 1'b1;
        // instr still holds the previous instruction whose writes finish here
        alu_ctrl  = exe_ctrl;
        alu_src_a = exe_src_a;
        reg_src   = (is_load || is_xfer) ? mov_src : REG_SRC_ALU;
        a_we      = (mov_dst == REG_DST_A);
        x_we      = (mov_dst == REG_DST_X);
        y_we      = (mov_dst == REG_DST_Y);
        p_src     = p_src_sel;
        p_mask    = flag_mask;
        pc_adder_ctrl = PC_ADD_INC;
        pcl_we = 1'b1;
        pch_we = 1'b1;
        abl_we = 1'b1;
        abh_we = 1'b1;
      end
      read_operand: begin
        dl_we = 1'b1;
        t_we  = 1'b1;
        // One-byte instructions leave the PC on the next opcode
        if (addr_mode == imp || addr_mode == acc) begin
          pc_adder_ctrl = PC_ADD_NOP;
        end else if (addr_mode == rel && branch_taken) begin
          pc_adder_ctrl = PC_ADD_ADD;
        end else begin
          pc_adder_ctrl = PC_ADD_INC;
        end
        pcl_we = 1'b1;
        pch_we = 1'b1;
        if (addr_mode == zpg) begin
          abl_src = AB_SRC_MEM;
          abh_src = AB_SRC_H00;
        end
        abl_we = 1'b1;
        abh_we = 1'b1;
      end
      abs_address: begin
        // Address high byte on the bus with the low byte already in T
        dl_we = 1'b1;
        pc_adder_ctrl = PC_ADD_INC;
        if (op == op_jmp) begin
          pcl_src = PCL_SRC_T;
          pch_src = PCH_SRC_MEM;
        end
        pcl_we  = 1'b1;
        pch_we  = 1'b1;
        abl_src = AB_SRC_T;
        abh_src = AB_SRC_MEM;
        abl_we  = 1'b1;
        abh_we  = 1'b1;
      end
      read_data: begin
        dl_we   = 1'b1;
        t_we    = 1'b1;
        abl_src = AB_SRC_PCC;
        abh_src = AB_SRC_PCC;
        abl_we  = 1'b1;
        abh_we  = 1'b1;
      end
      write_data: begin
        if (is_store) begin
          r_w = RW_WRITE;
        end
        case (op)
          op_stx:  db_out_src = DB_SRC_X;
          op_sty:  db_out_src = DB_SRC_Y;
          default: db_out_src = DB_SRC_A;
        endcase
        abl_src = AB_SRC_PCC;
        abh_src = AB_SRC_PCC;
        abl_we  = 1'b1;
        abh_we  = 1'b1;
      end
      branch_add: begin
        // PC holds the branch target so the bus points at it
        abl_src = AB_SRC_PCC;
        abh_src = AB_SRC_PCC;
        abl_we  = 1'b1;
        abh_we  = 1'b1;
      end
      default: begin
        ir_we = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/cpu_controller.sv */
`timescale 1ns/1ns

module cpu_controller
  import cpu_ctrl_pkg::*;
(
  input  logic         CLK,
  input  logic         rst_n,
  input  logic         rdy,
  input  logic [7:0]   instr,
  input  flags_t       flags,
  output logic         r_w,
  output db_src_t      db_out_src,
  output logic         dl_we,
  output logic         ir_we,
  output pc_add_t      pc_adder_ctrl,
  output pcl_src_t     pcl_src,
  output logic         pch_src,
  output logic         pcl_we,
  output logic         pch_we,
  output reg_src_t     reg_src,
  output logic         a_we,
  output logic         x_we,
  output logic         y_we,
  output logic         t_we,
  output p_src_t       p_src,
  output flags_t       p_mask,
  output alu_ctrl_t    alu_ctrl,
  output alu_src_a_t   alu_src_a,
  output alu_src_b_t   alu_src_b,
  output ab_src_t      abl_src,
  output ab_src_t      abh_src,
  output logic         abl_we,
  output logic         abh_we
);

  op_t          op;
  addr_mode_t   addr_mode;
  alu_ctrl_t    exe_ctrl;
  alu_src_a_t   exe_src_a;
  reg_src_t     mov_src;
  reg_dst_t     mov_dst;
  p_src_t       p_src_sel;
  flags_t       flag_mask;
  logic         is_load;
  logic         is_store;
  logic         is_xfer;
  cycle_state_t state;
  logic         branch_taken;

  // Decode, operand select, sequencing, then control generation
  opcode_decoder opcode_decoder_i (.*);

  operand_select operand_select_i (.*);

  cycle_sequencer cycle_sequencer_i (.*);

  control_decoder control_decoder_i (.*);

endmodule

/* rtl/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

  typedef enum logic [5:0] {
    op_nop,
    // ALU group in the order of opcode bits 7:5
    op_ora, op_and, op_eor, op_adc, op_sta, op_lda, op_cmp, op_sbc,
    // Branches also in the order of opcode bits 7:5
    op_bpl, op_bmi, op_bvc, op_bvs, op_bcc, op_bcs, op_bne, op_beq,
    op_ldx, op_ldy, op_stx, op_sty, op_cpx, op_cpy, op_bit,
    op_inx, op_iny, op_dex, op_dey,
    op_tax, op_tay, op_txa, op_tya,
    op_sec, op_sed, op_sei, op_clc, op_cld, op_cli, op_clv,
    op_jmp, op_asl, op_lsr, op_rol, op_ror
  } op_t;

  typedef enum logic [3:0] {imp, acc, imm, zpg, abs, rel} addr_mode_t;

  typedef enum logic [5:0] {
    fetch_opcode,
    read_operand,
    abs_address,
    read_data,
    write_data,
    branch_add
  } cycle_state_t;

  typedef logic [7:0] flags_t;
  typedef logic [3:0] alu_ctrl_t;
  typedef logic [2:0] alu_src_a_t;
  typedef logic [1:0] alu_src_b_t;
  typedef logic [2:0] reg_src_t;
  typedef logic [3:0] reg_dst_t;
  typedef logic [2:0] p_src_t;
  typedef logic [2:0] db_src_t;
  typedef logic [1:0] pc_add_t;
  typedef logic [1:0] pcl_src_t;
  typedef logic [2:0] ab_src_t;

  // Status register bit positions
  localparam flags_t FLAG_C = 8'h01;
  localparam flags_t FLAG_Z = 8'h02;
  localparam flags_t FLAG_I = 8'h04;
  localparam flags_t FLAG_D = 8'h08;
  localparam flags_t FLAG_V = 8'h40;
  localparam flags_t FLAG_N = 8'h80;

  localparam logic RW_READ  = 1'b1;
  localparam logic RW_WRITE = 1'b0;

  // THA passes operand A through unchanged
  localparam alu_ctrl_t ALU_THA = 4'd0;
  localparam alu_ctrl_t ALU_ADC = 4'd1;
  localparam alu_ctrl_t ALU_SBC = 4'd2;
  localparam alu_ctrl_t ALU_AND = 4'd3;
  localparam alu_ctrl_t ALU_ORA = 4'd4;
  localparam alu_ctrl_t ALU_EOR = 4'd5;
  localparam alu_ctrl_t ALU_CMP = 4'd6;
  localparam alu_ctrl_t ALU_BIT = 4'd7;
  localparam alu_ctrl_t ALU_INC = 4'd8;
  localparam alu_ctrl_t ALU_DEC = 4'd9;
  localparam alu_ctrl_t ALU_ASL = 4'd10;
  localparam alu_ctrl_t ALU_LSR = 4'd11;
  localparam alu_ctrl_t ALU_ROL = 4'd12;
  localparam alu_ctrl_t ALU_ROR = 4'd13;

  localparam alu_src_a_t ALU_SRC_A_A = 3'd0;
  localparam alu_src_a_t ALU_SRC_A_X = 3'd1;
  localparam alu_src_a_t ALU_SRC_A_Y = 3'd2;
  localparam alu_src_b_t ALU_SRC_B_T = 2'd0;

  localparam reg_src_t REG_SRC_MEM = 3'd0;
  localparam reg_src_t REG_SRC_ALU = 3'd1;
  localparam reg_src_t REG_SRC_T   = 3'd2;
  localparam reg_src_t REG_SRC_A   = 3'd3;
  localparam reg_src_t REG_SRC_X   = 3'd4;
  localparam reg_src_t REG_SRC_Y   = 3'd5;

  localparam reg_dst_t REG_DST_NONE = 4'd0;
  localparam reg_dst_t REG_DST_A    = 4'd1;
  localparam reg_dst_t REG_DST_X    = 4'd2;
  localparam reg_dst_t REG_DST_Y    = 4'd3;

  localparam p_src_t P_SRC_NON = 3'd0;
  localparam p_src_t P_SRC_ALU = 3'd1;
  localparam p_src_t P_SRC_SET = 3'd2;
  localparam p_src_t P_SRC_CLR = 3'd3;

  localparam db_src_t DB_SRC_A = 3'd0;
  localparam db_src_t DB_SRC_X = 3'd1;
  localparam db_src_t DB_SRC_Y = 3'd2;

  localparam pc_add_t PC_ADD_NOP = 2'd0;
  localparam pc_add_t PC_ADD_INC = 2'd1;
  localparam pc_add_t PC_ADD_ADD = 2'd2;

  localparam pcl_src_t PCL_SRC_ADD = 2'd0;
  localparam pcl_src_t PCL_SRC_T   = 2'd1;
  localparam logic     PCH_SRC_ADD = 1'b0;
  localparam logic     PCH_SRC_MEM = 1'b1;

  // PCN is the PC adder output and PCC the current PC
  localparam ab_src_t AB_SRC_PCN = 3'd0;
  localparam ab_src_t AB_SRC_PCC = 3'd1;
  localparam ab_src_t AB_SRC_T   = 3'd2;
  localparam ab_src_t AB_SRC_MEM = 3'd3;
  localparam ab_src_t AB_SRC_H00 = 3'd4;

endpackage

/* rtl/cycle_sequencer.sv */
`timescale 1ns/1ns

module cycle_sequencer
  import cpu_ctrl_pkg::*;
(
  input  logic         CLK,
  input  logic         rst_n,
  input  logic         rdy,
  input  op_t          op,
  input  addr_mode_t   addr_mode,
  input  logic         is_store,
  input  flags_t       flags,
  output cycle_state_t state,
  output logic         branch_taken
);

  cycle_state_t next_state;
  logic         c_set;
  logic         z_set;
  logic         v_set;
  logic         n_set;

  assign c_set = |(flags & FLAG_C);
  assign z_set = |(flags & FLAG_Z);
  assign v_set = |(flags & FLAG_V);
  assign n_set = |(flags & FLAG_N);

  always_comb begin
    case (op)
      op_bpl:  branch_taken = !n_set;
      op_bmi:  branch_taken = n_set;
      op_bvc:  branch_taken = !v_set;
      op_bvs:  branch_taken = v_set;
      op_bcc:  branch_taken = !c_set;
      op_bcs:  branch_taken = c_set;
      op_bne:  branch_taken = !z_set;
      op_beq:  branch_taken = z_set;
      default: branch_taken = 1'b0;
    endcase
  end

  // Low rdy freezes the cycle
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= fetch_opcode;
    end else if (rdy) begin
      state <= next_state;
    end
  end

  always_comb begin
    case (state)
      fetch_opcode: next_state = read_operand;
      read_operand: begin
        case (addr_mode)
          zpg:     next_state = is_store ? write_data : read_data;
          abs:     next_state = abs_address;
          // Untaken branch spends its third cycle on a dummy read
          rel:     next_state = branch_taken ? branch_add : read_data;
          default: next_state = fetch_opcode;
        endcase
      end
      abs_address: begin
        if (op == op_jmp) begin
          next_state = fetch_opcode;
        end else begin
          next_state = is_store ? write_data : read_data;
        end
      end
      default: next_state = fetch_opcode;
    endcase
  end

endmodule

/* rtl/opcode_decoder.sv */
`timescale 1ns/1ns

module opcode_decoder
  import cpu_ctrl_pkg::*;
(
  input  logic [7:0] instr,
  output op_t        op,
  output addr_mode_t addr_mode
);

  logic       grp_hit;
  addr_mode_t grp_mode;
  logic [9:0] table_out;

  // ALU group is aaabbb01; only zero page, immediate and absolute kept
  assign grp_hit = (instr[1:0] == 2'b01) && (instr[4:2] inside {3'd1, 3'd2, 3'd3}) &&
                   (instr != 8'h89);

  always_comb begin
    case (instr[4:2])
      3'd1:    grp_mode = zpg;
      3'd2:    grp_mode = imm;
      default: grp_mode = abs;
    endcase
  end

  // Remaining opcodes as {op, mode}
  always_comb begin
    case (instr)
      8'hA2:   table_out = {op_ldx, imm};
      8'hA6:   table_out = {op_ldx, zpg};
      8'hAE:   table_out = {op_ldx, abs};
      8'hA0:   table_out = {op_ldy, imm};
      8'hA4:   table_out = {op_ldy, zpg};
      8'hAC:   table_out = {op_ldy, abs};
      8'h86:   table_out = {op_stx, zpg};
      8'h8E:   table_out = {op_stx, abs};
      8'h84:   table_out = {op_sty, zpg};
      8'h8C:   table_out = {op_sty, abs};
      8'hE0:   table_out = {op_cpx, imm};
      8'hE4:   table_out = {op_cpx, zpg};
      8'hEC:   table_out = {op_cpx, abs};
      8'hC0:   table_out = {op_cpy, imm};
      8'hC4:   table_out = {op_cpy, zpg};
      8'hCC:   table_out = {op_cpy, abs};
      8'h24:   table_out = {op_bit, zpg};
      8'h2C:   table_out = {op_bit, abs};
      8'hE8:   table_out = {op_inx, imp};
      8'hC8:   table_out = {op_iny, imp};
      8'hCA:   table_out = {op_dex, imp};
      8'h88:   table_out = {op_dey, imp};
      8'hAA:   table_out = {op_tax, imp};
      8'hA8:   table_out = {op_tay, imp};
      8'h8A:   table_out = {op_txa, imp};
      8'h98:   table_out = {op_tya, imp};
      8'h38:   table_out = {op_sec, imp};
      8'hF8:   table_out = {op_sed, imp};
      8'h78:   table_out = {op_sei, imp};
      8'h18:   table_out = {op_clc, imp};
      8'hD8:   table_out = {op_cld, imp};
      8'h58:   table_out = {op_cli, imp};
      8'hB8:   table_out = {op_clv, imp};
      8'h4C:   table_out = {op_jmp, abs};
      8'h0A:   table_out = {op_asl, acc};
      8'h4A:   table_out = {op_lsr, acc};
      8'h2A:   table_out = {op_rol, acc};
      8'h6A:   table_out = {op_ror, acc};
      default: table_out = {op_nop, imp};
    endcase
  end

  always_comb begin
    if (grp_hit) begin
      op        = op_t'(op_ora + instr[7:5]);
      addr_mode = grp_mode;
    end else if (instr[4:0] == 5'b10000) begin
      // Branches are xxx10000
      op        = op_t'(op_bpl + instr[7:5]);
      addr_mode = rel;
    end else begin
      op        = op_t'(table_out[9:4]);
      addr_mode = addr_mode_t'(table_out[3:0]);
    end
  end

endmodule

/* rtl/operand_select.sv */
`timescale 1ns/1ns

module operand_select
  import cpu_ctrl_pkg::*;
(
  input  op_t        op,
  input  addr_mode_t addr_mode,
  output alu_ctrl_t  exe_ctrl,
  output alu_src_a_t exe_src_a,
  output reg_src_t   mov_src,
  output reg_dst_t   mov_dst,
  output p_src_t     p_src_sel,
  output flags_t     flag_mask,
  output logic       is_load,
  output logic       is_store,
  output logic       is_xfer
);

  assign is_load  = op inside {op_lda, op_ldx, op_ldy};
  assign is_store = op inside {op_sta, op_stx, op_sty};
  assign is_xfer  = op inside {op_tax, op_tay, op_txa, op_tya};

  assign exe_src_a = (op inside {op_cpx, op_inx, op_dex}) ? ALU_SRC_A_X :
                     (op inside {op_cpy, op_iny, op_dey}) ? ALU_SRC_A_Y : ALU_SRC_A_A;

  always_comb begin
    case (op)
      op_adc:                 exe_ctrl = ALU_ADC;
      op_sbc:                 exe_ctrl = ALU_SBC;
      op_and:                 exe_ctrl = ALU_AND;
      op_ora:                 exe_ctrl = ALU_ORA;
      op_eor:                 exe_ctrl = ALU_EOR;
      op_cmp, op_cpx, op_cpy: exe_ctrl = ALU_CMP;
      op_bit:                 exe_ctrl = ALU_BIT;
      op_inx, op_iny:         exe_ctrl = ALU_INC;
      op_dex, op_dey:         exe_ctrl = ALU_DEC;
      // Shifts only act on A in accumulator mode
      op_asl:                 exe_ctrl = (addr_mode == acc) ? ALU_ASL : ALU_THA;
      op_lsr:                 exe_ctrl = (addr_mode == acc) ? ALU_LSR : ALU_THA;
      op_rol:                 exe_ctrl = (addr_mode == acc) ? ALU_ROL : ALU_THA;
      op_ror:                 exe_ctrl = (addr_mode == acc) ? ALU_ROR : ALU_THA;
      default:                exe_ctrl = ALU_THA;
    endcase
  end

  always_comb begin
    case (op)
      op_tax, op_tay: mov_src = REG_SRC_A;
      op_txa:         mov_src = REG_SRC_X;
      op_tya:         mov_src = REG_SRC_Y;
      // Loaded byte waits in T
      default:        mov_src = REG_SRC_T;
    endcase
  end

  always_comb begin
    case (op)
      op_lda, op_txa, op_tya, op_adc, op_sbc, op_and, op_ora, op_eor,
      op_asl, op_lsr, op_rol, op_ror:   mov_dst = REG_DST_A;
      op_ldx, op_tax, op_inx, op_dex:   mov_dst = REG_DST_X;
      op_ldy, op_tay, op_iny, op_dey:   mov_dst = REG_DST_Y;
      default:                          mov_dst = REG_DST_NONE;
    endcase
  end

  always_comb begin
    case (op)
      op_sec, op_sed, op_sei:         p_src_sel = P_SRC_SET;
      op_clc, op_cld, op_cli, op_clv: p_src_sel = P_SRC_CLR;
      default: p_src_sel = (exe_ctrl == ALU_THA) ? P_SRC_NON : P_SRC_ALU;
    endcase
  end

  always_comb begin
    case (op)
      op_sec, op_clc: flag_mask = FLAG_C;
      op_sed, op_cld: flag_mask = FLAG_D;
      op_sei, op_cli: flag_mask = FLAG_I;
      op_clv:         flag_mask = FLAG_V;
      op_adc, op_sbc: flag_mask = FLAG_N | FLAG_V | FLAG_Z | FLAG_C;
      op_bit:         flag_mask = FLAG_N | FLAG_V | FLAG_Z;
      op_cmp, op_cpx, op_cpy, op_asl, op_lsr, op_rol, op_ror:
                      flag_mask = FLAG_N | FLAG_Z | FLAG_C;
      default:        flag_mask = (exe_ctrl == ALU_THA) ? '0 : (FLAG_N | FLAG_Z);
    endcase
  end

endmodule

/* tests/controller_vectors.txt */
// opcode flags stall length dst store, one instruction per line
// dst and store codes: 0 none, 1 A, 2 X, 3 Y
A9 00 0 2 1 0
A6 00 1 3 2 0
AC 00 2 4 3 0
85 00 0 3 0 1
8E 00 3 4 0 2
84 00 1 3 0 3
65 00 0 3 1 0
ED 00 2 4 1 0
C9 00 1 2 0 0
E8 00 0 2 2 0
88 00 2 2 3 0
AA 00 0 2 2 0
98 00 1 2 1 0
38 00 0 2 0 0
58 00 1 2 0 0
B8 00 0 2 0 0
F0 02 1 3 0 0
D0 02 0 3 0 0
10 80 2 3 0 0
70 40 0 3 0 0
4C 00 1 3 0 0
0A 00 0 2 1 0
2C 00 3 4 0 0
02 00 0 2 0 0

/* tests/cpu_controller_properties.sv */
`timescale 1ns/1ns

module cpu_controller_properties
  import cpu_ctrl_pkg::*;
(
  input logic       CLK,
  input logic       rst_n,
  input logic       rdy,
  input logic       r_w,
  input db_src_t    db_out_src,
  input logic       dl_we,
  input logic       ir_we,
  input pc_add_t    pc_adder_ctrl,
  input pcl_src_t   pcl_src,
  input logic       pch_src,
  input logic       pcl_we,
  input logic       pch_we,
  input reg_src_t   reg_src,
  input logic       a_we,
  input logic       x_we,
  input logic       y_we,
  input logic       t_we,
  input p_src_t     p_src,
  input flags_t     p_mask,
  input alu_ctrl_t  alu_ctrl,
  input alu_src_a_t alu_src_a,
  input alu_src_b_t alu_src_b,
  input ab_src_t    abl_src,
  input ab_src_t    abh_src,
  input logic       abl_we,
  input logic       abh_we
);

  // Number of failed assertions
  int prop_failures = 0;

  // Write cycles never load the instruction register
  write_no_fetch: assert property (@(posedge CLK) disable iff (!rst_n)
    (r_w == RW_WRITE) |-> !ir_we)
    else begin
      $error("ir_we high during a write cycle");
      prop_failures++;
    end

  // Opcode and data latch loads are exclusive
  ir_dl_exclusive: assert property (@(posedge CLK) disable iff (!rst_n)
    !(ir_we && dl_we))
    else begin
      $error("ir_we and dl_we high in the same cycle");
      prop_failures++;
    end

  // A stalled cycle repeats on the next clock
  stall_holds: assert property (@(posedge CLK) disable iff (!rst_n)
    !rdy |=> $stable({r_w, db_out_src, dl_we, ir_we, pc_adder_ctrl, pcl_src, pch_src,
                      pcl_we, pch_we, reg_src, a_we, x_we, y_we, t_we, p_src, p_mask,
                      alu_ctrl, alu_src_a, alu_src_b, abl_src, abh_src, abl_we, abh_we}))
    else begin
      $error("control outputs changed after a cycle with rdy low");
      prop_failures++;
    end

endmodule

/* tests/tb_cpu_controller.sv */
`timescale 1ns/1ns

module tb_cpu_controller;
  import cpu_ctrl_pkg::*;

  localparam int NUM_VEC = 24;
  localparam int FIELDS = 6;
  localparam int RESET_CYCLES = 16;

  logic CLK;
  logic rst_n;
  logic rdy;
  logic [7:0] instr;
  flags_t flags;
  logic r_w;
  db_src_t db_out_src;
  logic dl_we;
  logic ir_we;
  pc_add_t pc_adder_ctrl;
  pcl_src_t pcl_src;
  logic pch_src;
  logic pcl_we;
  logic pch_we;
  reg_src_t reg_src;
  logic a_we;
  logic x_we;
  logic y_we;
  logic t_we;
  p_src_t p_src;
  flags_t p_mask;
  alu_ctrl_t alu_ctrl;
  alu_src_a_t alu_src_a;
  alu_src_b_t alu_src_b;
  ab_src_t abl_src;
  ab_src_t abh_src;
  logic abl_we;
  logic abh_we;

  // Fields per line are opcode, flags, stall, length, dst and store
  logic [7:0] vec_mem [0:NUM_VEC*FIELDS-1];
  integer seed;
  int errors;
  int prop_errors;
  int checks;
  int cycle_count;
  int timeout_limit;

  cpu_controller cpu_controller_i (.*);

  bind cpu_controller cpu_controller_properties properties_i (
    .CLK(CLK), .rst_n(rst_n), .rdy(rdy), .r_w(r_w), .db_out_src(db_out_src),
    .dl_we(dl_we), .ir_we(ir_we), .pc_adder_ctrl(pc_adder_ctrl), .pcl_src(pcl_src),
    .pch_src(pch_src), .pcl_we(pcl_we), .pch_we(pch_we), .reg_src(reg_src),
    .a_we(a_we), .x_we(x_we), .y_we(y_we), .t_we(t_we), .p_src(p_src),
    .p_mask(p_mask), .alu_ctrl(alu_ctrl), .alu_src_a(alu_src_a),
    .alu_src_b(alu_src_b), .abl_src(abl_src), .abh_src(abh_src),
    .abl_we(abl_we), .abh_we(abh_we)
  );

  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles, the DUT never returned to its fetch cycle",
               cycle_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic string test_name(input int idx);
    return $sformatf("vec%0d_op%02h", idx, vec_mem[idx*FIELDS]);
  endfunction

  // Bits 7:6 of a branch opcode pick N, V, C or Z and bit 5 the level wanted
  function automatic logic branch_condition(input logic [7:0] opc, input flags_t fl);
    logic flag_bit;
    case (opc[7:6])
      2'b00:   flag_bit = fl[7];
      2'b01:   flag_bit = fl[6];
      2'b10:   flag_bit = fl[0];
      default: flag_bit = fl[1];
    endcase
    return (opc[4:0] == 5'b10000) && (flag_bit == opc[5]);
  endfunction

  // Expected status source and mask of the flag opcodes as {src, mask}
  function automatic logic [10:0] flag_op_expect(input logic [7:0] opc);
    case (opc)
      8'h38:   flag_op_expect = {P_SRC_SET, FLAG_C};
      8'hF8:   flag_op_expect = {P_SRC_SET, FLAG_D};
      8'h78:   flag_op_expect = {P_SRC_SET, FLAG_I};
      8'h18:   flag_op_expect = {P_SRC_CLR, FLAG_C};
      8'hD8:   flag_op_expect = {P_SRC_CLR, FLAG_D};
      8'h58:   flag_op_expect = {P_SRC_CLR, FLAG_I};
      8'hB8:   flag_op_expect = {P_SRC_CLR, FLAG_V};
      default: flag_op_expect = {P_SRC_NON, 8'h00};
    endcase
  endfunction

  task automatic check_value(input string name, input string what,
                             input int expected, input int actual);
    checks++;
    assert (actual == expected) else begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", name, what, expected, actual);
      errors++;
    end
  endtask

  // Called in the fetch cycle that still carries instruction idx
  task automatic compare_commit(input int idx);
    string name;
    int dst;
    logic [10:0] exp_p;
    name = test_name(idx);
    dst = vec_mem[idx*FIELDS+4];
    exp_p = flag_op_expect(vec_mem[idx*FIELDS]);
    check_value(name, "a_we", dst == 1, a_we);
    check_value(name, "x_we", dst == 2, x_we);
    check_value(name, "y_we", dst == 3, y_we);
    if (exp_p[10:8] != P_SRC_NON) begin
      check_value(name, "p_src", exp_p[10:8], p_src);
      check_value(name, "p_mask", exp_p[7:0], p_mask);
    end
  endtask

  // Starts in a fetch cycle and returns in the next one
  task automatic run_instruction(input int idx);
    string name;
    logic [7:0] v_op;
    flags_t v_flags;
    int stall;
    int len;
    int store;
    int stall_pos;
    int cyc;
    int writes;
    logic done;
    name = test_name(idx);
    v_op = vec_mem[idx*FIELDS];
    v_flags = vec_mem[idx*FIELDS+1];
    stall = vec_mem[idx*FIELDS+2];
    len = vec_mem[idx*FIELDS+3];
    store = vec_mem[idx*FIELDS+5];
    stall_pos = 1 + ($unsigned($random(seed)) % (len - 1));
    cyc = 1;
    writes = 0;
    done = 1'b0;
    @(posedge CLK);
    instr <= v_op;
    flags <= v_flags;
    rdy <= !((cyc >= stall_pos) && (cyc < stall_pos + stall));
    while (!done) begin
      @(negedge CLK);
      if (ir_we) begin
        done = 1'b1;
      end else begin
        if (cyc == 1) begin
          check_value(name, "pc_add_branch", branch_condition(v_op, v_flags),
                      pc_adder_ctrl == PC_ADD_ADD);
        end
        if (r_w == RW_WRITE) begin
          // Store source codes 1..3 map onto A, X, Y
          check_value(name, "db_out_src", store - 1, db_out_src);
          if (rdy) begin
            writes++;
          end
        end
        @(posedge CLK);
        cyc++;
        rdy <= !((cyc >= stall_pos) && (cyc < stall_pos + stall));
      end
    end
    check_value(name, "length", len + stall, cyc);
    check_value(name, "write_cycles", store != 0, writes);
  endtask

  initial begin
    CLK = 1'b0;
    rst_n = 1'b0;
    rdy = 1'b1;
    instr = 8'hEA;
    flags = 8'h00;
    seed = 96768;
    errors = 0;
    prop_errors = 0;
    checks = 0;
    cycle_count = 0;
    $readmemh("tests/controller_vectors.txt", vec_mem);
    timeout_limit = RESET_CYCLES;
    for (int i = 0; i < NUM_VEC; i++) begin
      timeout_limit += (vec_mem[i*FIELDS+3] + vec_mem[i*FIELDS+2]) * 2;
    end

    repeat (RESET_CYCLES) @(posedge CLK);
    rst_n <= 1'b1;
    @(negedge CLK);
    check_value("after_reset", "ir_we", 1, ir_we);
    check_value("after_reset", "r_w", RW_READ, r_w);
    check_value("after_reset", "dl_we", 0, dl_we);
    check_value("after_reset", "reg_we", 0, {a_we, x_we, y_we, t_we});

    for (int i = 0; i < NUM_VEC; i++) begin
      if (i > 0) begin
        compare_commit(i - 1);
      end
      run_instruction(i);
    end
    compare_commit(NUM_VEC - 1);

    prop_errors = cpu_controller_i.properties_i.prop_failures;
    $display("Checks run: %0d, errors: %0d, property failures: %0d",
             checks, errors, prop_errors);
    if (errors == 0 && prop_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
